// ==== design/aesPkg.sv ====
/*
 AES-128 shared definitions
 widths, round count, key-schedule seed and control states
 for the iterative composite-field encryption core
*/

package aesPkg;

   // ----------------------------------------
   // data widths
   // ----------------------------------------

   // 16 bytes, most significant byte is byte 0 of the state
   typedef logic [127:0] block_t;

   // one state column / key word
   typedef logic [31:0] word_t;

   // GF(2^8) element
   typedef logic [7:0] byte_t;

   // GF(2^4) element, upper and lower GF(2^2) halves
   typedef logic [3:0] nibble_t;

   // round index 0..10
   typedef logic [3:0] roundCnt_t;

   // ----------------------------------------
   // algorithm constants
   // ----------------------------------------

   localparam roundCnt_t NUM_ROUNDS = 4'd10;

   // rcon of round 1, doubled each round after
   localparam byte_t RCON_INIT = 8'h01;

   // x^8 = x^4 + x^3 + x + 1 reduction for xtime
   localparam byte_t XTIME_POLY = 8'h1B;

   // top-level control
   typedef enum logic {
      IDLE,
      RUN
   } ctrlState_t;

endpackage

// ==== design/gfInv4.sv ====
/*
 GF(2^4) multiplicative inverse
 element held as two GF(2^2) halves, phi = 2'b10
*/

`timescale 1ns/1ps

module gfInv4 (
   input  aesPkg::nibble_t x,
   output aesPkg::nibble_t y
);

   logic [1:0] hi;
   logic [1:0] lo;
   logic [1:0] hiLo;
   logic [1:0] norm;
   logic [1:0] normInv;

   // ----------------------------------------
   // GF(2^2) helpers, basis z^2 = z + 1
   // ----------------------------------------

   function automatic logic [1:0] gfSq2(input logic [1:0] a);
      gfSq2 = {a[1], a[1] ^ a[0]};
   endfunction

   function automatic logic [1:0] gfMul2(input logic [1:0] a, input logic [1:0] b);
      gfMul2[1] = (a[1] & b[1]) ^ (a[1] & b[0]) ^ (a[0] & b[1]);
      gfMul2[0] = (a[1] & b[1]) ^ (a[0] & b[0]);
   endfunction

   // times phi = z
   function automatic logic [1:0] gfMulPhi(input logic [1:0] a);
      gfMulPhi = {a[1] ^ a[0], a[1]};
   endfunction

   // in GF(4) a^-1 = a^2, zero maps to zero
   function automatic logic [1:0] gfInv2(input logic [1:0] a);
      gfInv2 = gfSq2(a);
   endfunction

   // split, norm, invert norm, scale back
   assign hi   = x[3:2];
   assign lo   = x[1:0];
   assign hiLo = hi ^ lo;

   assign norm    = gfMulPhi(gfSq2(hi)) ^ gfMul2(hiLo, lo);
   assign normInv = gfInv2(norm);

   assign y = {gfMul2(hi, normInv), gfMul2(hiLo, normInv)};

endmodule

// ==== design/sboxComposite.sv ====
/*
 AES S-box, one byte
 GF(2^8) inverse computed in GF((2^4)^2), lambda = 4'b1100,
 followed by the AES affine map
*/

`timescale 1ns/1ps

module sboxComposite
   import aesPkg::*;
(
   input  byte_t x,
   output byte_t y
);

   // row i of each matrix gives output bit i
   localparam byte_t ISO_ROWS [0:7] = '{
      8'b0100_0011, 8'b0101_0010, 8'b1001_1110, 8'b1100_0110,
      8'b1010_1110, 8'b1010_1100, 8'b1101_1110, 8'b1010_0000
   };
   localparam byte_t ISO_INV_ROWS [0:7] = '{
      8'b0111_0101, 8'b0011_0000, 8'b1001_1110, 8'b0011_1110,
      8'b0111_0110, 8'b0110_0010, 8'b0100_0100, 8'b1110_0010
   };
   localparam byte_t AFFINE_C = 8'h63;

   byte_t   xMapped;
   byte_t   invMapped;
   nibble_t g1;
   nibble_t g0;
   nibble_t g1g0;
   nibble_t delta;
   nibble_t deltaInv;

   // ----------------------------------------
   // field helpers
   // ----------------------------------------

   function automatic byte_t bitMatrix(input byte_t v, input byte_t rows [0:7]);
      byte_t r;
      for (int i = 0; i < 8; i++) begin
         r[i] = ^(v & rows[i]);
      end
      return r;
   endfunction

   function automatic nibble_t gfSq4(input nibble_t a);
      gfSq4[3] = a[3];
      gfSq4[2] = a[3] ^ a[2];
      gfSq4[1] = a[2] ^ a[1];
      gfSq4[0] = a[3] ^ a[1] ^ a[0];
   endfunction

   // flattened form of the GF(2^2) pair product
   function automatic nibble_t gfMul4(input nibble_t a, input nibble_t b);
      gfMul4[3] = a[3] & b[3] ^ a[3] & b[2] ^ a[3] & b[1] ^ a[3] & b[0]
                ^ a[2] & b[3] ^ a[2] & b[1] ^ a[1] & b[3] ^ a[1] & b[2]
                ^ a[0] & b[3];
      gfMul4[2] = a[3] & b[3] ^ a[3] & b[1] ^ a[2] & b[2] ^ a[2] & b[0]
                ^ a[1] & b[3] ^ a[0] & b[2];
      gfMul4[1] = a[3] & b[2] ^ a[2] & b[3] ^ a[2] & b[2] ^ a[1] & b[1]
                ^ a[1] & b[0] ^ a[0] & b[1];
      gfMul4[0] = a[3] & b[3] ^ a[3] & b[2] ^ a[2] & b[3] ^ a[1] & b[1]
                ^ a[0] & b[0];
   endfunction

   // times lambda = 4'b1100
   function automatic nibble_t gfMulLambda(input nibble_t a);
      gfMulLambda[3] = a[2] ^ a[0];
      gfMulLambda[2] = a[3] ^ a[2] ^ a[1] ^ a[0];
      gfMulLambda[1] = a[3];
      gfMulLambda[0] = a[2];
   endfunction

   // b ^ b<<<1 ^ b<<<2 ^ b<<<3 ^ b<<<4 ^ 63
   function automatic byte_t affine(input byte_t b);
      affine = b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]}
             ^ {b[3:0], b[7:4]} ^ AFFINE_C;
   endfunction

   // into the composite field
   assign xMapped = bitMatrix(x, ISO_ROWS);
   assign g1      = xMapped[7:4];
   assign g0      = xMapped[3:0];
   assign g1g0    = g1 ^ g0;

   // norm down to GF(2^4), invert there
   assign delta = gfMulLambda(gfSq4(g1)) ^ gfMul4(g1g0, g0);

   gfInv4 deltaInvert (
      .x(delta),
      .y(deltaInv)
   );

   assign invMapped = {gfMul4(g1, deltaInv), gfMul4(g1g0, deltaInv)};

   // back to the AES basis, then affine
   assign y = affine(bitMatrix(invMapped, ISO_INV_ROWS));

endmodule

// ==== design/roundDatapath.sv ====
/*
 AES encryption round, combinational
 SubBytes, ShiftRows, MixColumns (skipped in the last round),
 AddRoundKey over the full 128-bit state
*/

`timescale 1ns/1ps

module roundDatapath
   import aesPkg::*;
(
   input  block_t stateIn,
   input  block_t roundKey,
   input  logic   finalRound,
   output block_t stateOut
);

   block_t subBlk;
   block_t shiftBlk;
   block_t mixBlk;

   function automatic byte_t xtime(input byte_t b);
      xtime = {b[6:0], 1'b0} ^ (b[7] ? XTIME_POLY : 8'h00);
   endfunction

   // 2 3 1 1 circulant on one column
   function automatic word_t mixColumn(input word_t col);
      byte_t a0, a1, a2, a3;
      byte_t b0, b1, b2, b3;
      a0 = col[31:24];
      a1 = col[23:16];
      a2 = col[15:8];
      a3 = col[7:0];
      b0 = xtime(a0);
      b1 = xtime(a1);
      b2 = xtime(a2);
      b3 = xtime(a3);
      mixColumn = {b0 ^ a1 ^ b1 ^ a2 ^ a3,
                   a0 ^ b1 ^ a2 ^ b2 ^ a3,
                   a0 ^ a1 ^ b2 ^ a3 ^ b3,
                   a0 ^ b0 ^ a1 ^ a2 ^ b3};
   endfunction

   // ----------------------------------------
   // SubBytes, byte i at bits 127-8i
   // ----------------------------------------
   for (genvar i = 0; i < 16; i++) begin : gSub
      sboxComposite sboxInst (
         .x(stateIn[127-8*i -: 8]),
         .y(subBlk[127-8*i -: 8])
      );
   end

   // ----------------------------------------
   // ShiftRows and MixColumns
   // ----------------------------------------

   // byte 4c+r, row r rotates left by r columns
   for (genvar c = 0; c < 4; c++) begin : gCol
      for (genvar r = 0; r < 4; r++) begin : gRow
         assign shiftBlk[127-8*(4*c+r) -: 8] = subBlk[127-8*(4*((c+r)%4)+r) -: 8];
      end
      assign mixBlk[127-32*c -: 32] = mixColumn(shiftBlk[127-32*c -: 32]);
   end

   // last round has no MixColumns
   assign stateOut = (finalRound ? shiftBlk : mixBlk) ^ roundKey;

endmodule

// ==== design/keySchedule.sv ====
/*
 AES-128 key schedule, expanded on the fly
 holds the cipher key, the previous round key and rcon,
 and derives the current round key combinationally
*/

`timescale 1ns/1ps

module keySchedule
   import aesPkg::*;
(
   input  logic   CLK,
   input  logic   rst,
   input  logic   EN,
   input  logic   loadKey,
   input  logic   start,
   input  logic   advance,
   input  block_t Kin,
   output block_t cipherKey,
   output block_t roundKey
);

   block_t keyReg;
   block_t prevKey;
   byte_t  rcon;
   word_t  rotWord;
   word_t  subWord;
   word_t  tempWord;
   word_t  w0;
   word_t  w1;
   word_t  w2;
   word_t  w3;

   // new key is visible in the same cycle it is loaded
   assign cipherKey = loadKey ? Kin : keyReg;

   // ----------------------------------------
   // next round key
   // ----------------------------------------
   assign rotWord = {prevKey[23:0], prevKey[31:24]};

   for (genvar i = 0; i < 4; i++) begin : gSubWord
      sboxComposite sboxInst (
         .x(rotWord[8*i +: 8]),
         .y(subWord[8*i +: 8])
      );
   end

   assign tempWord = subWord ^ {rcon, 24'h000000};

   // chained words
   assign w0 = tempWord ^ prevKey[127:96];
   assign w1 = w0 ^ prevKey[95:64];
   assign w2 = w1 ^ prevKey[63:32];
   assign w3 = w2 ^ prevKey[31:0];

   assign roundKey = {w0, w1, w2, w3};

   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         keyReg  <= '0;
         prevKey <= '0;
         rcon    <= RCON_INIT;
      end else if (EN) begin
         if (loadKey) begin
            keyReg <= Kin;
         end
         // restart from round 0 key
         if (start) begin
            prevKey <= cipherKey;
            rcon    <= RCON_INIT;
         end else if (advance) begin
            prevKey <= roundKey;
            rcon    <= {rcon[6:0], 1'b0} ^ (rcon[7] ? XTIME_POLY : 8'h00);
         end
      end
   end

endmodule

// ==== design/aesEncrypt.sv ====
/*
 Iterative AES-128 encryption core
 one round per enabled clock, on-the-fly key expansion,
 Krdy/Kvld, Drdy/Dvld handshake with EN stall and BSY flag
*/

`timescale 1ns/1ps

module aesEncrypt
   import aesPkg::*;
(
   input  logic   CLK,
   input  logic   rst,
   input  logic   EN,
   input  block_t Kin,
   input  block_t Din,
   input  logic   Krdy,
   input  logic   Drdy,
   output block_t Dout,
   output logic   Kvld,
   output logic   Dvld,
   output logic   BSY
);

   ctrlState_t ctrlState;
   roundCnt_t  roundCnt;
   block_t     stateReg;
   block_t     cipherKey;
   block_t     roundKey;
   block_t     roundOut;
   logic       loadKey;
   logic       start;
   logic       advance;
   logic       finalRound;

   // ----------------------------------------
   // handshake decode
   // ----------------------------------------

   // loads only while idle
   assign BSY     = (ctrlState == RUN);
   assign loadKey = Krdy & ~BSY;
   assign start   = Drdy & ~BSY;

   assign advance    = BSY;
   assign finalRound = (roundCnt == NUM_ROUNDS);

   keySchedule keySched (
      .CLK(CLK),
      .rst(rst),
      .EN(EN),
      .loadKey(loadKey),
      .start(start),
      .advance(advance),
      .Kin(Kin),
      .cipherKey(cipherKey),
      .roundKey(roundKey)
   );

   roundDatapath round (
      .stateIn(stateReg),
      .roundKey(roundKey),
      .finalRound(finalRound),
      .stateOut(roundOut)
   );

   // ----------------------------------------
   // control FSM and round counter
   // ----------------------------------------
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         ctrlState <= IDLE;
         roundCnt  <= '0;
         Kvld      <= 1'b0;
         Dvld      <= 1'b0;
      end else if (EN) begin
         Kvld <= loadKey;
         Dvld <= 1'b0;
         case (ctrlState)
            IDLE: begin
               if (start) begin
                  ctrlState <= RUN;
                  roundCnt  <= 4'd1;
               end
            end
            RUN: begin
               // round 10 writes the ciphertext
               if (finalRound) begin
                  ctrlState <= IDLE;
                  roundCnt  <= '0;
                  Dvld      <= 1'b1;
               end else begin
                  roundCnt <= roundCnt + 4'd1;
               end
            end
            default: begin
               ctrlState <= IDLE;
            end
         endcase
      end
   end

   // ----------------------------------------
   // state register
   // ----------------------------------------

   // initial AddRoundKey on load, one round per enabled edge after
   always_ff @(posedge CLK or posedge rst) begin
      if (rst) begin
         stateReg <= '0;
      end else if (EN) begin
         if (start) begin
            stateReg <= Din ^ cipherKey;
         end else if (advance) begin
            stateReg <= roundOut;
         end
      end
   end

   // ciphertext held until the next accepted Drdy
   assign Dout = stateReg;

endmodule

// ==== verification/aesEncryptTb.sv ====
/*
 Testbench for the iterative AES-128 encryption core
 directed tests with FIPS-197 vectors, EN stalls,
 latency and busy-protection checks
*/

`timescale 1ns/1ps

module aesEncryptTb
   import aesPkg::*;
();

   localparam int CLK_PERIOD      = 20;
   localparam int RESET_CYCLES    = 8;
   localparam int ROUND_EDGES     = 10;
   localparam int WATCHDOG_CYCLES = 3000;
   localparam int SEED            = 96360;

   // FIPS-197 appendix vectors
   localparam block_t KEY_A   = 128'h2b7e151628aed2a6abf7158809cf4f3c;
   localparam block_t PLAIN_A = 128'h3243f6a8885a308d313198a2e0370734;
   localparam block_t CIPH_A  = 128'h3925841d02dc09fbdc118597196a0b32;
   localparam block_t KEY_B   = 128'h000102030405060708090a0b0c0d0e0f;
   localparam block_t PLAIN_B = 128'h00112233445566778899aabbccddeeff;
   localparam block_t CIPH_B  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
   localparam block_t CIPH_Z  = 128'h66e94bd4ef8a2c3b884cfa59ca342b2e;

   logic   CLK;
   logic   rst;
   logic   EN;
   block_t Kin;
   block_t Din;
   logic   Krdy;
   logic   Drdy;
   block_t Dout;
   logic   Kvld;
   logic   Dvld;
   logic   BSY;

   aesEncrypt aesEncrypt_i (
      .CLK(CLK),
      .rst(rst),
      .EN(EN),
      .Kin(Kin),
      .Din(Din),
      .Krdy(Krdy),
      .Drdy(Drdy),
      .Dout(Dout),
      .Kvld(Kvld),
      .Dvld(Dvld),
      .BSY(BSY)
   );

   always #(CLK_PERIOD / 2) CLK = ~CLK;

   // ----------------------------------------
   // failure handling and compare tasks
   // ----------------------------------------

   task automatic failAndStop();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic checkBlock(input block_t actual, input block_t expected, input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
         failAndStop();
      end
   endtask

   task automatic checkFlag(input logic actual, input logic expected, input string what);
      if (actual !== expected) begin
         $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
         failAndStop();
      end
   endtask

   // watchdog over the whole run
   initial begin
      #(CLK_PERIOD * WATCHDOG_CYCLES);
      $display("Timeout: the tests did not finish within %0d clock periods", WATCHDOG_CYCLES);
      failAndStop();
   end

   // ----------------------------------------
   // stimulus helpers
   // ----------------------------------------

   // each task starts and ends at a falling edge

   // key load and one-cycle Kvld check
   task automatic loadCipherKey(input block_t key);
      Kin  = key;
      Krdy = 1'b1;
      EN   = 1'b1;
      @(negedge CLK);
      Krdy = 1'b0;
      checkFlag(Kvld, 1'b1, "Kvld after key load");
      @(negedge CLK);
      checkFlag(Kvld, 1'b0, "Kvld one cycle only");
   endtask

   // one block with optional random EN stalls
   // and foreign Drdy/Krdy pulses while busy
   task automatic encryptBlock(input block_t plain, input block_t cipher,
                               input bit stall, input bit intrude);
      int enEdges;
      int cycles;
      enEdges = 0;
      cycles  = 0;
      Din  = plain;
      Drdy = 1'b1;
      EN   = 1'b1;
      @(negedge CLK);
      Drdy = 1'b0;
      checkFlag(BSY, 1'b1, "BSY after Drdy");
      forever begin
         EN = stall ? (($urandom % 2) == 1) : 1'b1;
         // foreign data and key mid-block
         if (intrude && cycles == 3) begin
            Din  = PLAIN_B;
            Kin  = KEY_B;
            Drdy = 1'b1;
            Krdy = 1'b1;
         end else begin
            Drdy = 1'b0;
            Krdy = 1'b0;
         end
         @(posedge CLK);
         if (EN) begin
            enEdges++;
         end
         cycles++;
         @(negedge CLK);
         if (Dvld || enEdges >= ROUND_EDGES) begin
            break;
         end
         checkFlag(BSY, 1'b1, "BSY during rounds");
         checkFlag(Kvld, 1'b0, "Kvld while busy");
      end
      Drdy = 1'b0;
      Krdy = 1'b0;
      if (!Dvld) begin
         $display("Error at %0t ns: Dvld did not rise within %0d enabled edges after Drdy",
                  $time, ROUND_EDGES);
         failAndStop();
      end
      checkFlag(enEdges == ROUND_EDGES, 1'b1, "Dvld after 10 enabled edges");
      checkFlag(BSY, 1'b0, "BSY cleared with Dvld");
      checkBlock(Dout, cipher, "ciphertext");
   endtask

   // Dvld low and Dout steady after the block
   task automatic expectResultHeld(input block_t cipher, input int holdCycles);
      EN = 1'b1;
      repeat (holdCycles) begin
         @(negedge CLK);
         checkFlag(Dvld, 1'b0, "Dvld one cycle only");
         checkFlag(BSY, 1'b0, "BSY idle after block");
         checkBlock(Dout, cipher, "ciphertext held");
      end
   endtask

   // ----------------------------------------
   // directed tests
   // ----------------------------------------

   task automatic resetFlags();
      checkFlag(Kvld, 1'b0, "Kvld after reset");
      checkFlag(Dvld, 1'b0, "Dvld after reset");
      checkFlag(BSY, 1'b0, "BSY after reset");
      checkBlock(Dout, '0, "state after reset");
      loadCipherKey(KEY_A);
   endtask

   // reload of the key between blocks
   task automatic knownAnswers();
      loadCipherKey(KEY_A);
      encryptBlock(PLAIN_A, CIPH_A, 1'b0, 1'b0);
      expectResultHeld(CIPH_A, 1);
      loadCipherKey(KEY_B);
      encryptBlock(PLAIN_B, CIPH_B, 1'b0, 1'b0);
      expectResultHeld(CIPH_B, 1);
      loadCipherKey('0);
      encryptBlock('0, CIPH_Z, 1'b0, 1'b0);
      expectResultHeld(CIPH_Z, 1);
   endtask

   task automatic latencyAndHold();
      loadCipherKey(KEY_B);
      encryptBlock(PLAIN_B, CIPH_B, 1'b0, 1'b0);
      expectResultHeld(CIPH_B, 5);
   endtask

   task automatic randomStall();
      loadCipherKey(KEY_A);
      encryptBlock(PLAIN_A, CIPH_A, 1'b1, 1'b0);
      expectResultHeld(CIPH_A, 2);
   endtask

   // second block starts in the Dvld cycle with the stored key
   task automatic busyProtection();
      loadCipherKey(KEY_A);
      encryptBlock(PLAIN_A, CIPH_A, 1'b0, 1'b1);
      encryptBlock(PLAIN_A, CIPH_A, 1'b0, 1'b0);
      expectResultHeld(CIPH_A, 2);
   endtask

   initial begin
      CLK  = 1'b0;
      rst  = 1'b1;
      EN   = 1'b0;
      Kin  = '0;
      Din  = '0;
      Krdy = 1'b0;
      Drdy = 1'b0;
      void'($urandom(SEED));
      repeat (RESET_CYCLES) @(posedge CLK);
      @(negedge CLK);
      rst = 1'b0;
      resetFlags();
      knownAnswers();
      latencyAndHold();
      randomStall();
      busyProtection();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

// ==== verilog.f ====
design/aesPkg.sv
design/gfInv4.sv
design/sboxComposite.sv
design/roundDatapath.sv
design/keySchedule.sv
design/aesEncrypt.sv
verification/aesEncryptTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the AES-128 core testbench with Verilator.
# The exit status is the simulator's: nonzero on any failure.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
   -f verilog.f \
   --top-module aesEncryptTb \
   -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/VaesEncryptTb
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit $status
fi

exit 0
